// ==== include/stats_config.svh ====
`ifndef STATS_CONFIG_SVH
`define STATS_CONFIG_SVH

// Sample width in bits
`define STATS_WIDTH 8

// Number of independent channels
`define STATS_CHANNELS 4

// Bits compared per pipeline stage; must divide STATS_WIDTH
`define STATS_BITS_PER_STAGE 4

`endif

// ==== src/stats_pkg.sv ====
`default_nettype none

`include "stats_config.svh"

package stats_pkg;

  localparam int WIDTH          = `STATS_WIDTH;
  localparam int CHANNELS       = `STATS_CHANNELS;
  localparam int BITS_PER_STAGE = `STATS_BITS_PER_STAGE;

  // One channel still needs a one-bit index
  localparam int CHAN_W = (CHANNELS > 1) ? $clog2(CHANNELS) : 1;

  // Compare stages in each tracker; 1 means a direct compare
  localparam int STAGES = WIDTH / BITS_PER_STAGE;

  typedef logic [WIDTH-1:0]  sample_t;
  typedef logic [CHAN_W-1:0] chan_t;

endpackage

`default_nettype wire

// ==== src/stats_chan_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// One channel's path from the dispatcher through a tracker to the readout
interface stats_chan_if;

  // Sample strobe for this channel
  logic               en;
  // Clear strobe, wins over en in the same cycle
  logic               clr;
  // Sample value, shared by all channels
  stats_pkg::sample_t val;
  // Running maximum since the last clear
  stats_pkg::sample_t max;

  modport feed  (output en, output clr, output val);
  modport unit  (input en, input clr, input val, output max);
  modport drain (input max);

endinterface

`default_nettype wire

// ==== src/stats_dispatch.sv ====
`timescale 1ns/1ns
`default_nettype none

module stats_dispatch (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                in_valid,
  input  stats_pkg::chan_t   in_chan,
  input  stats_pkg::sample_t in_data,
  input  wire                clr_valid,
  input  stats_pkg::chan_t   clr_chan,
  input  wire                clr_all,
  stats_chan_if.feed         chans [stats_pkg::CHANNELS]
);

  localparam int CHANNELS = stats_pkg::CHANNELS;

  // Decoded strobes, one bit per channel
  logic [CHANNELS-1:0] en_d;
  logic [CHANNELS-1:0] clr_d;

  logic [CHANNELS-1:0] en_q;
  logic [CHANNELS-1:0] clr_q;
  // Single copy of the sample, seen by every tracker
  stats_pkg::sample_t  val_q;

  always_comb begin
    for (int i = 0; i < CHANNELS; i++) begin
      en_d[i]  = in_valid && (in_chan == stats_pkg::chan_t'(i));
      // clr_all overrides the channel select
      clr_d[i] = clr_all || (clr_valid && (clr_chan == stats_pkg::chan_t'(i)));
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      en_q  <= '0;
      clr_q <= '0;
    end else begin
      en_q  <= en_d;
      clr_q <= clr_d;
    end
  end

  // Payload only moves with a sample
  always_ff @(posedge clk) begin
    if (in_valid) begin
      val_q <= in_data;
    end
  end

  for (genvar i = 0; i < CHANNELS; i++) begin : g_chan
    assign chans[i].en  = en_q[i];
    assign chans[i].clr = clr_q[i];
    assign chans[i].val = val_q;
  end

endmodule

`default_nettype wire

// ==== src/stats_max.sv ====
`timescale 1ns/1ns
`default_nettype none

module stats_max #(
  parameter int WIDTH          = stats_pkg::WIDTH,
  parameter int BITS_PER_STAGE = stats_pkg::BITS_PER_STAGE
) (
  input  wire        clk,
  input  wire        rst_n,
  stats_chan_if.unit ch
);

  localparam int STAGES = WIDTH / BITS_PER_STAGE;

  // Slices must tile the word exactly
  if (STAGES * BITS_PER_STAGE != WIDTH) begin : g_bad_split
    $error("BITS_PER_STAGE must divide WIDTH");
  end

  logic [WIDTH-1:0] max_q;

  if (STAGES == 1) begin : g_direct
    // Whole word compared in one cycle
    always_ff @(posedge clk) begin
      if (!rst_n || ch.clr) begin
        max_q <= '0;
      end else if (ch.en && (ch.val > max_q)) begin
        max_q <= ch.val;
      end
    end
  end else begin : g_pipe
    for (genvar s = 0; s < STAGES; s++) begin : g_stage
      // Stage 0 looks at the top slice
      localparam int HI = (STAGES - s) * BITS_PER_STAGE - 1;

      logic [WIDTH-1:0]          smp_in;
      logic                      vld_in;
      logic                      gt_in;
      logic [BITS_PER_STAGE-1:0] slc;
      logic [BITS_PER_STAGE-1:0] ref_slc;

      logic [WIDTH-1:0]          smp_q;
      logic                      vld_q;
      // Sample already known to beat the max at an upper slice
      logic                      gt_q;

      if (s == 0) begin : g_head
        assign smp_in = ch.val;
        assign vld_in = ch.en;
        assign gt_in  = 1'b0;
      end else begin : g_body
        assign smp_in = g_stage[s-1].smp_q;
        assign vld_in = g_stage[s-1].vld_q;
        assign gt_in  = g_stage[s-1].gt_q;
      end

      assign slc     = smp_in[HI -: BITS_PER_STAGE];
      // Compared against the max as it stands now, which only grows
      assign ref_slc = max_q[HI -: BITS_PER_STAGE];

      // Undecided and smaller here means it can never win, so drop it
      always_ff @(posedge clk) begin
        if (!rst_n || ch.clr) begin
          vld_q <= 1'b0;
        end else begin
          vld_q <= vld_in && (gt_in || (slc >= ref_slc));
        end
      end

      always_ff @(posedge clk) begin
        smp_q <= smp_in;
        gt_q  <= gt_in || (slc > ref_slc);
      end
    end

    // Final full compare; max may have grown while this sample was in flight.
    // Samples equal on every slice arrive with gt clear and are ignored
    always_ff @(posedge clk) begin
      if (!rst_n || ch.clr) begin
        max_q <= '0;
      end else if (g_stage[STAGES-1].vld_q && g_stage[STAGES-1].gt_q &&
                   (g_stage[STAGES-1].smp_q > max_q)) begin
        max_q <= g_stage[STAGES-1].smp_q;
      end
    end
  end

  assign ch.max = max_q;

endmodule

`default_nettype wire

// ==== src/stats_readout.sv ====
`timescale 1ns/1ns
`default_nettype none

module stats_readout (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                rd_en,
  input  stats_pkg::chan_t   rd_chan,
  stats_chan_if.drain        chans [stats_pkg::CHANNELS],
  output stats_pkg::sample_t rd_data,
  output logic               rd_valid
);

  localparam int CHANNELS = stats_pkg::CHANNELS;
  // Every index value has an entry, unused ones read as zero
  localparam int SLOTS    = 2 ** stats_pkg::CHAN_W;

  stats_pkg::sample_t max_arr [SLOTS];

  for (genvar i = 0; i < SLOTS; i++) begin : g_slot
    if (i < CHANNELS) begin : g_used
      assign max_arr[i] = chans[i].max;
    end else begin : g_unused
      assign max_arr[i] = '0;
    end
  end

  // One-cycle pulse per read
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_en;
    end
  end

  // Holds the last value read until the next read
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= max_arr[rd_chan];
    end
  end

endmodule

`default_nettype wire

// ==== src/stats_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "stats_config.svh"

module stats_top (
  input  wire                clk,
  input  wire                rst_n,

  // Tagged sample strobe
  input  wire                in_valid,
  input  stats_pkg::chan_t   in_chan,
  input  stats_pkg::sample_t in_data,

  // Clears, one channel or all
  input  wire                clr_valid,
  input  stats_pkg::chan_t   clr_chan,
  input  wire                clr_all,

  // Host read port, answered one cycle later
  input  wire                rd_en,
  input  stats_pkg::chan_t   rd_chan,
  output stats_pkg::sample_t rd_data,
  output logic               rd_valid
);

  stats_chan_if chans [`STATS_CHANNELS] ();

  // Sample and clear decode
  stats_dispatch dispatch_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_chan  (in_chan),
    .in_data  (in_data),
    .clr_valid(clr_valid),
    .clr_chan (clr_chan),
    .clr_all  (clr_all),
    .chans    (chans)
  );

  // One tracker per channel
  for (genvar i = 0; i < `STATS_CHANNELS; i++) begin : g_max
    stats_max #(
      .WIDTH         (`STATS_WIDTH),
      .BITS_PER_STAGE(`STATS_BITS_PER_STAGE)
    ) max_i (
      .clk  (clk),
      .rst_n(rst_n),
      .ch   (chans[i])
    );
  end

  stats_readout readout_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .rd_en   (rd_en),
    .rd_chan (rd_chan),
    .chans   (chans),
    .rd_data (rd_data),
    .rd_valid(rd_valid)
  );

endmodule

`default_nettype wire

// ==== sim/stats_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

// Protocol and monotonic checks on the collector internals
module stats_assertions (
  input wire                     clk,
  input wire                     rst_n,
  input wire                     rd_en,
  input wire                     rd_valid,
  input wire [stats_pkg::CHANNELS-1:0] en,
  input wire [stats_pkg::CHANNELS-1:0] clr,
  input stats_pkg::sample_t      max_arr [2 ** stats_pkg::CHAN_W]
);

  // Dispatcher addresses at most one channel per sample
  assert property (@(posedge clk) disable iff (!rst_n) $onehot0(en))
    else $error("en strobes are not one-hot");

  // Every rd_valid pulse answers a read from the cycle before
  assert property (@(posedge clk) disable iff (!rst_n) rd_valid |-> $past(rd_en))
    else $error("rd_valid without a preceding rd_en");

  // Maximum only drops right after a clear
  for (genvar i = 0; i < stats_pkg::CHANNELS; i++) begin : g_mono
    assert property (@(posedge clk) disable iff (!rst_n)
                     (max_arr[i] >= $past(max_arr[i])) || $past(clr[i]))
      else $error("channel %0d maximum decreased without a clear", i);
  end

endmodule

bind stats_top stats_assertions assertions_i (
  .clk     (clk),
  .rst_n   (rst_n),
  .rd_en   (rd_en),
  .rd_valid(rd_valid),
  .en      (dispatch_i.en_q),
  .clr     (dispatch_i.clr_q),
  .max_arr (readout_i.max_arr)
);

`default_nettype wire

// ==== sim/stats_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module stats_tb;

  localparam int CH   = stats_pkg::CHANNELS;
  // Cycles from the last stimulus to the first read that must see it
  localparam int WAIT = stats_pkg::STAGES + 2;
  localparam int RC   = WAIT + 2;
  // Rough sum of all test lengths plus margin
  localparam int CYCLE_LIMIT = 13 + CH * RC + 4 * (1 + RC) + 2 * (8 + RC) + 40 + CH * RC
                             + 40 + 4 * CH * RC + 300 * RC + CH * RC + 200;

  logic               clk;
  logic               rst_n;
  logic               in_valid;
  stats_pkg::chan_t   in_chan;
  stats_pkg::sample_t in_data;
  logic               clr_valid;
  stats_pkg::chan_t   clr_chan;
  logic               clr_all;
  logic               rd_en;
  stats_pkg::chan_t   rd_chan;
  stats_pkg::sample_t rd_data;
  logic               rd_valid;

  // Reference maxima and reads awaiting an answer
  stats_pkg::sample_t exp_max [CH];
  stats_pkg::sample_t exp_q [$];

  int errors;
  int tests_pass;
  int tests_fail;
  int test_start_err;
  int cycles;

  stats_top stats_top_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_chan  (in_chan),
    .in_data  (in_data),
    .clr_valid(clr_valid),
    .clr_chan (clr_chan),
    .clr_all  (clr_all),
    .rd_en    (rd_en),
    .rd_chan  (rd_chan),
    .rd_data  (rd_data),
    .rd_valid (rd_valid)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Clear beats sample, otherwise keep the larger value
  function automatic stats_pkg::sample_t next_max(stats_pkg::sample_t cur,
                                                  stats_pkg::sample_t val,
                                                  logic en, logic clr);
    if (clr) return '0;
    if (en && (val > cur)) return val;
    return cur;
  endfunction

  task automatic check_sample(stats_pkg::sample_t got, stats_pkg::sample_t exp,
                              string what);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_valid(logic got, logic exp);
    if (got !== exp) begin
      $display("Fail at %0t: rd_valid is %b expected %b", $time, got, exp);
      errors++;
    end
  endtask

  // Drive one cycle of inputs and advance the reference
  task automatic issue(logic iv, stats_pkg::chan_t ich, stats_pkg::sample_t idat,
                       logic cv, stats_pkg::chan_t cch, logic ca,
                       logic re, stats_pkg::chan_t rch);
    @(posedge clk);
    in_valid  <= iv;
    in_chan   <= ich;
    in_data   <= idat;
    clr_valid <= cv;
    clr_chan  <= cch;
    clr_all   <= ca;
    rd_en     <= re;
    rd_chan   <= rch;
    for (int i = 0; i < CH; i++) begin
      exp_max[i] = next_max(exp_max[i], idat, iv && (ich == stats_pkg::chan_t'(i)),
                            ca || (cv && (cch == stats_pkg::chan_t'(i))));
    end
    if (re) exp_q.push_back(exp_max[rch]);
  endtask

  task automatic idle(int n);
    repeat (n) issue(0, '0, '0, 0, '0, 0, 0, '0);
  endtask

  task automatic sample(stats_pkg::chan_t c, stats_pkg::sample_t v);
    issue(1, c, v, 0, '0, 0, 0, '0);
  endtask

  task automatic read_chan(stats_pkg::chan_t c);
    idle(WAIT - 1);
    issue(0, '0, '0, 0, '0, 0, 1, c);
    idle(2);
  endtask

  task automatic read_all();
    for (int i = 0; i < CH; i++) read_chan(stats_pkg::chan_t'(i));
  endtask

  task automatic begin_test();
    test_start_err = errors;
  endtask

  task automatic end_test(string name);
    if (errors == test_start_err) begin
      tests_pass++;
      $display("Test %s: pass", name);
    end else begin
      tests_fail++;
      $display("Test %s: fail, %0d errors", name, errors - test_start_err);
    end
  endtask

  // Compare process, sampled at the falling edge where outputs are stable
  initial begin : compare
    logic en_seen;
    forever begin
      @(posedge clk);
      en_seen = rd_en;
      @(negedge clk);
      if (rst_n) begin
        check_valid(rd_valid, en_seen);
        if (en_seen) begin
          if (exp_q.size() == 0) begin
            $display("Read answered with no expected value queued at %0t", $time);
            errors++;
          end else begin
            check_sample(rd_data, exp_q.pop_front(), "rd_data");
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the run did not finish", cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin
    int r;
    stats_pkg::chan_t c;
    void'($urandom(32'hcbef8d27));
    errors = 0;
    tests_pass = 0;
    tests_fail = 0;
    cycles = 0;
    rst_n = 1'b0;
    in_valid = 1'b0;
    in_chan = '0;
    in_data = '0;
    clr_valid = 1'b0;
    clr_chan = '0;
    clr_all = 1'b0;
    rd_en = 1'b0;
    rd_chan = '0;
    for (int i = 0; i < CH; i++) exp_max[i] = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    begin_test();
    idle(10);
    read_all();
    end_test("reset_zero");

    begin_test();
    sample(0, 8'h42);
    read_chan(0);
    sample(0, 8'h64);
    read_chan(0);
    sample(0, 8'h32);
    read_chan(0);
    sample(0, 8'hFF);
    read_chan(0);
    end_test("directed");

    // Big value first, then smaller ones still in flight
    begin_test();
    sample(1, 8'h10);
    sample(1, 8'hC0);
    sample(1, 8'h20);
    sample(1, 8'hBF);
    sample(1, 8'h05);
    read_chan(1);
    for (int i = 0; i < 8; i++) sample(2, stats_pkg::sample_t'($urandom));
    read_chan(2);
    end_test("burst");

    begin_test();
    for (int i = 0; i < 40; i++) begin
      sample(stats_pkg::chan_t'($urandom % CH), stats_pkg::sample_t'($urandom));
    end
    read_all();
    end_test("interleaved");

    begin_test();
    for (int i = 0; i < CH; i++) sample(stats_pkg::chan_t'(i), 8'h80 + i);
    issue(0, '0, '0, 1, 1, 0, 0, '0);
    read_all();
    // Clear and sample together, clear wins
    issue(1, 2, 8'hEE, 1, 2, 0, 0, '0);
    read_all();
    for (int i = 0; i < CH; i++) sample(stats_pkg::chan_t'(i), 8'h70 + i);
    issue(0, '0, '0, 0, '0, 1, 0, '0);
    read_all();
    end_test("clear");

    begin_test();
    for (int i = 0; i < 300; i++) begin
      r = $urandom % 20;
      c = stats_pkg::chan_t'($urandom % CH);
      if (r < 11) sample(c, stats_pkg::sample_t'($urandom));
      else if (r < 13) issue($urandom % 2, c, stats_pkg::sample_t'($urandom), 1, c, 0, 0, '0);
      else if (r == 13) issue(0, '0, '0, 0, '0, 1, 0, '0);
      else if (r < 17) read_chan(c);
      else idle(1);
    end
    read_all();
    end_test("random_mix");

    $display("Tests passed %0d, failed %0d, check errors %0d", tests_pass, tests_fail, errors);
    if (errors == 0 && tests_fail == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
src/stats_pkg.sv
src/stats_chan_if.sv
src/stats_dispatch.sv
src/stats_max.sv
src/stats_readout.sv
src/stats_top.sv
sim/stats_assertions.sv
sim/stats_tb.sv

// ==== Makefile ====
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module stats_tb -f src.f -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/Vstats_tb > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "ERRORS FOUND" $(LOG); then exit 1; fi; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
